/* design/fpClassPkg.sv */
package fpClassPkg;

	// ====================
	// binary32 layout
	// ====================
	// sign at the top, then the biased exponent, then the stored mantissa
	localparam int fpWid   = 32;	// whole word
	localparam int expMsb  = 7;	// exponent field is expMsb+1 = 8 bits
	localparam int fracMsb = 22;	// mantissa field is fracMsb+1 = 23 bits

	// ====================
	// vector shape
	// ====================
	localparam int numLanes = 4;	// words per vector
	localparam int laneIdxW = 2;	// wide enough to index numLanes

	// ====================
	// class code
	// ====================
	// one-hot, same bit meaning as the risc-v fclass result
	localparam int classW = 10;

	// negative side
	localparam int clsNegInf  = 0;	// -inf
	localparam int clsNegNorm = 1;	// negative normal
	localparam int clsNegSub  = 2;	// negative subnormal
	localparam int clsNegZero = 3;	// -0

	// positive side
	localparam int clsPosZero = 4;	// +0
	localparam int clsPosSub  = 5;	// positive subnormal
	localparam int clsPosNorm = 6;	// positive normal
	localparam int clsPosInf  = 7;	// +inf

	// NaNs ignore the sign
	localparam int clsSnan = 8;	// signalling, mantissa msb clear
	localparam int clsQnan = 9;	// quiet, mantissa msb set

	// quick sanity relations
	// classW covers clsNegInf..clsQnan
	// numLanes is a power of two so the lane index wraps on its own

endpackage

/* design/fpLaneLoader.sv */
module fpLaneLoader (
	input  logic clk,
	input  logic rstN,
	input  logic [fpClassPkg::fpWid-1:0] wordIn,	// one binary32 word
	input  logic wordValid,	// strobe, one per word
	output logic [fpClassPkg::numLanes*fpClassPkg::fpWid-1:0] laneWord,	// lane 0 in low bits
	output logic loadCe	// one cycle per full vector
);
	import fpClassPkg::*;

	// ====================
	// staging
	// ====================
	logic [laneIdxW-1:0] laneIdx;	// lane the next word lands in
	logic [numLanes-1:0][fpWid-1:0] stage;	// partially filled vector
	logic [numLanes-1:0][fpWid-1:0] stageNext;	// stage with this cycle's word merged in
	logic lastLane;	// current word completes the vector

	assign lastLane = (laneIdx == laneIdxW'(numLanes - 1));

	// drop the incoming word into its slot
	always_comb begin
		stageNext = stage;
		if (wordValid)
			stageNext[laneIdx] = wordIn;
	end

	// ====================
	// data path
	// ====================
	always_ff @(posedge clk) begin
		stage <= stageNext;
		// hand the full vector over, staging is free to refill next cycle
		if (wordValid && lastLane)
			laneWord <= stageNext;	// includes the word arriving now
	end

	// ====================
	// control
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			laneIdx <= '0;
			loadCe <= 1'b0;
		end else begin
			loadCe <= wordValid && lastLane;	// lanes capture on the next edge
			if (wordValid)
				laneIdx <= lastLane ? '0 : laneIdx + 1'b1;	// round-robin
		end
	end

endmodule

/* design/fpDecompReg.sv */
module fpDecompReg (
	input  logic clk,
	input  logic ce,	// capture enable
	input  logic [fpClassPkg::fpWid-1:0] i,	// raw binary32 word
	output logic [fpClassPkg::fpWid-1:0] o,	// registered copy of i
	output logic sgn,
	output logic [fpClassPkg::expMsb:0] exp,	// biased exponent
	output logic [fpClassPkg::fracMsb:0] man,	// stored mantissa
	output logic [fpClassPkg::fracMsb+1:0] fract,	// mantissa with hidden bit
	output logic xz,	// exponent zero, denormal or zero
	output logic mz,	// mantissa zero
	output logic vz,	// value zero
	output logic inf,	// all-ones exponent, zero mantissa
	output logic xinf,	// all-ones exponent
	output logic qnan,	// quiet nan
	output logic snan,	// signalling nan
	output logic nan	// any nan
);
	import fpClassPkg::*;

	// ====================
	// field split
	// ====================
	logic [expMsb:0] expIn;
	logic [fracMsb:0] manIn;
	logic expZero;
	logic manZero;
	logic expOnes;

	assign expIn = i[fpWid-2:fracMsb+1];	// between sign and mantissa
	assign manIn = i[fracMsb:0];
	assign expZero = ~|expIn;
	assign manZero = ~|manIn;
	assign expOnes = &expIn;	// inf or nan

	// ====================
	// registered outputs
	// ====================
	// flags come straight from the input fields so every
	// output belongs to the same captured word
	always_ff @(posedge clk) begin
		if (ce) begin
			o <= i;
			sgn <= i[fpWid-1];
			exp <= expIn;
			man <= manIn;
			fract <= {~expZero, manIn};	// hidden bit only for normals

			xz <= expZero;
			mz <= manZero;
			vz <= expZero & manZero;	// +0 or -0
			inf <= expOnes & manZero;
			xinf <= expOnes;

			// nan split on the mantissa msb
			qnan <= expOnes & manIn[fracMsb];
			snan <= expOnes & ~manIn[fracMsb] & ~manZero;	// payload must be nonzero
			nan <= expOnes & ~manZero;
		end
	end

endmodule

/* design/fpClassMerge.sv */
module fpClassMerge (
	input  logic clk,
	input  logic rstN,
	input  logic laneCe,	// lanes capture on the coming edge
	input  logic [fpClassPkg::numLanes-1:0] laneSgn,
	input  logic [fpClassPkg::numLanes-1:0] laneXz,
	input  logic [fpClassPkg::numLanes-1:0] laneMz,
	input  logic [fpClassPkg::numLanes-1:0] laneVz,
	input  logic [fpClassPkg::numLanes-1:0] laneInf,
	input  logic [fpClassPkg::numLanes-1:0] laneQnan,
	input  logic [fpClassPkg::numLanes-1:0] laneSnan,
	input  logic [fpClassPkg::numLanes-1:0] laneNan,
	output logic [fpClassPkg::numLanes*fpClassPkg::classW-1:0] classVec,	// lane 0 low
	output logic anySnan,
	output logic anyNan,
	output logic outValid
);
	import fpClassPkg::*;

	logic [numLanes-1:0][classW-1:0] classNext;	// one-hot code per lane
	logic snanNext;
	logic nanNext;
	logic laneVld;	// lane registers hold a fresh vector

	// ====================
	// per-lane class
	// ====================
	always_comb begin
		classNext = '0;
		for (int l = 0; l < numLanes; l++) begin
			if (laneSnan[l])
				classNext[l][clsSnan] = 1'b1;
			else if (laneQnan[l] || laneNan[l])
				classNext[l][clsQnan] = 1'b1;	// any nan left over is quiet
			else if (laneInf[l])
				classNext[l][laneSgn[l] ? clsNegInf : clsPosInf] = 1'b1;
			else if (laneVz[l])
				classNext[l][laneSgn[l] ? clsNegZero : clsPosZero] = 1'b1;
			else if (laneXz[l] && !laneMz[l])
				classNext[l][laneSgn[l] ? clsNegSub : clsPosSub] = 1'b1;	// denormal
			else
				classNext[l][laneSgn[l] ? clsNegNorm : clsPosNorm] = 1'b1;
		end
	end

	// ====================
	// summary flags
	// ====================
	always_comb begin
		snanNext = 1'b0;
		nanNext = 1'b0;
		for (int l = 0; l < numLanes; l++) begin
			snanNext = snanNext | classNext[l][clsSnan];
			nanNext = nanNext | classNext[l][clsSnan] | classNext[l][clsQnan];
		end
	end

	// ====================
	// output stage
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			laneVld <= 1'b0;
			outValid <= 1'b0;
		end else begin
			laneVld <= laneCe;	// lanes updated on this edge
			outValid <= laneVld;	// single-cycle pulse, two edges after laneCe
		end
	end

	// results load once per vector
	always_ff @(posedge clk) begin
		if (laneVld) begin
			classVec <= classNext;
			anySnan <= snanNext;
			anyNan <= nanNext;
		end
	end

endmodule

/* design/fpClassVec.sv */
module fpClassVec (
	input  logic clk,
	input  logic rstN,
	input  logic [fpClassPkg::fpWid-1:0] wordIn,
	input  logic wordValid,	// one strobe per word
	output logic [fpClassPkg::numLanes*fpClassPkg::classW-1:0] classVec,	// lane 0 low
	output logic anySnan,	// some lane is a signalling nan
	output logic anyNan,	// some lane is a nan
	output logic outValid	// one pulse per vector
);
	import fpClassPkg::*;

	// ====================
	// interconnect
	// ====================
	logic [numLanes*fpWid-1:0] laneWord;	// loader to lanes
	logic loadCe;	// lane capture enable
	logic [numLanes-1:0] laneSgn;	// lane flags to merge
	logic [numLanes-1:0] laneXz;
	logic [numLanes-1:0] laneMz;
	logic [numLanes-1:0] laneVz;
	logic [numLanes-1:0] laneInf;
	logic [numLanes-1:0] laneQnan;
	logic [numLanes-1:0] laneSnan;
	logic [numLanes-1:0] laneNan;

	// word strobe in, full vector out
	fpLaneLoader loader (
		.clk(clk),
		.rstN(rstN),
		.wordIn(wordIn),
		.wordValid(wordValid),
		.laneWord(laneWord),
		.loadCe(loadCe)
	);

	// one decomposer per lane, field outputs not needed here
	for (genvar g = 0; g < numLanes; g++) begin : genLane
		fpDecompReg decomp (
			.clk(clk),
			.ce(loadCe),
			.i(laneWord[g*fpWid +: fpWid]),
			.o(),
			.sgn(laneSgn[g]),
			.exp(),
			.man(),
			.fract(),
			.xz(laneXz[g]),
			.mz(laneMz[g]),
			.vz(laneVz[g]),
			.inf(laneInf[g]),
			.xinf(),
			.qnan(laneQnan[g]),
			.snan(laneSnan[g]),
			.nan(laneNan[g])
		);
	end

	// flags to class codes and summary
	fpClassMerge merge (
		.clk(clk),
		.rstN(rstN),
		.laneCe(loadCe),
		.laneSgn(laneSgn),
		.laneXz(laneXz),
		.laneMz(laneMz),
		.laneVz(laneVz),
		.laneInf(laneInf),
		.laneQnan(laneQnan),
		.laneSnan(laneSnan),
		.laneNan(laneNan),
		.classVec(classVec),
		.anySnan(anySnan),
		.anyNan(anyNan),
		.outValid(outValid)
	);

endmodule

/* tb/fpClassVec_sva.sv */
module fpClassVecSva (
	input logic clk,
	input logic rstN,
	input logic loadCe,	// loader to lanes
	input logic outValid,
	input logic [fpClassPkg::numLanes*fpClassPkg::classW-1:0] classVec
);
	import fpClassPkg::*;

	// ====================
	// strobe timing
	// ====================
	loadCePulse: assert property (@(posedge clk) disable iff (!rstN)
		loadCe |=> !loadCe)
		else $error("loadCe lasted longer than one cycle");

	// lanes capture one edge later, merge registers on the next
	outAfterLoad: assert property (@(posedge clk) disable iff (!rstN)
		loadCe |-> ##2 outValid)
		else $error("outValid did not follow loadCe by two edges");

	outFromLoad: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> $past(loadCe, 2))
		else $error("outValid without a loadCe two edges before");

	// ====================
	// class code shape
	// ====================
	for (genvar g = 0; g < numLanes; g++) begin : genOneHot
		laneOneHot: assert property (@(posedge clk) disable iff (!rstN)
			outValid |-> $onehot(classVec[g*classW +: classW]))
			else $error("lane %0d class code is not one-hot", g);
	end

endmodule

bind fpClassVec fpClassVecSva sva (
	.clk(clk),
	.rstN(rstN),
	.loadCe(loadCe),
	.outValid(outValid),
	.classVec(classVec)
);

/* tb/fpClassVecTb.sv */
module fpClassVecTb;
	import fpClassPkg::*;

	localparam int numWords = 20;	// entries in the stimulus file
	localparam int numVecs = numWords / numLanes;
	localparam int stimW = 12 + fpWid;	// 3 hex digits of class, then the word
	localparam int waitMax = 20;	// cycles to wait for outValid

	logic clk;
	logic rstN;
	logic [fpWid-1:0] wordIn;
	logic wordValid;
	logic [numLanes*classW-1:0] classVec;
	logic anySnan;
	logic anyNan;
	logic outValid;

	logic [stimW-1:0] stimMem [numWords];
	logic [31:0] lcgState;
	int wordCount;	// accepted words so far, both passes

	fpClassVec UUT (
		.clk(clk),
		.rstN(rstN),
		.wordIn(wordIn),
		.wordValid(wordValid),
		.classVec(classVec),
		.anySnan(anySnan),
		.anyNan(anyNan),
		.outValid(outValid)
	);

	always #5 clk = ~clk;

	// monitor, counts strobes the dut really samples
	always @(posedge clk) begin
		if (!rstN)
			wordCount <= 0;
		else if (wordValid)
			wordCount <= wordCount + 1;
	end

	// ====================
	// reference model
	// ====================
	function automatic logic [classW-1:0] refClass(input logic [fpWid-1:0] w);
		logic [classW-1:0] c;
		logic s;
		logic [expMsb:0] e;
		logic [fracMsb:0] m;
		c = '0;
		s = w[fpWid-1];
		e = w[fpWid-2 -: expMsb+1];
		m = w[fracMsb:0];
		if (&e) begin	// inf or nan
			if (m == '0)
				c[s ? clsNegInf : clsPosInf] = 1'b1;
			else if (m[fracMsb])
				c[clsQnan] = 1'b1;
			else
				c[clsSnan] = 1'b1;
		end else if (e == '0)
			c[(m == '0) ? (s ? clsNegZero : clsPosZero) : (s ? clsNegSub : clsPosSub)] = 1'b1;
		else
			c[s ? clsNegNorm : clsPosNorm] = 1'b1;
		return c;
	endfunction

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ====================
	// compare tasks
	// ====================
	task automatic compareClass(input string name, input logic [classW-1:0] got,
		input logic [classW-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "class code compare failed");
		end
	endtask

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "flag compare failed");
		end
	endtask

	// ====================
	// driver and checker
	// ====================
	task automatic driveWords();
		int gap;
		for (int p = 0; p < 2; p++) begin	// pass 0 random gaps, pass 1 back-to-back
			for (int w = 0; w < numWords; w++) begin
				lcgState = lcgNext(lcgState);
				gap = (p == 0) ? int'((lcgState >> 16) % 3) : 0;
				repeat (gap) begin
					@(posedge clk);
					wordValid <= 1'b0;
				end
				@(posedge clk);
				wordIn <= stimMem[w][fpWid-1:0];
				wordValid <= 1'b1;
			end
		end
		@(posedge clk);
		wordValid <= 1'b0;
	endtask

	task automatic waitOutValid(input int vecNum);
		int cycles;
		cycles = 0;
		while (outValid !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > waitMax) begin
				$display("timeout: the output strobe never came for vector %0d", vecNum);
				$display("TEST FAILED");
				$fatal(1, "outValid wait timed out");
			end
		end
	endtask

	task automatic checkVector(input int v);
		logic [classW-1:0] expCls;
		logic expSnan;
		logic expNan;
		int base;
		base = (v % numVecs) * numLanes;
		expSnan = 1'b0;
		expNan = 1'b0;
		if (wordCount < numLanes * (v + 1)) begin
			$display("vector %0d came out before its four words were sent", v);
			$display("TEST FAILED");
			$fatal(1, "early output vector");
		end
		for (int l = 0; l < numLanes; l++) begin
			expCls = stimMem[base+l][fpWid +: classW];
			compareClass($sformatf("classVec lane %0d", l), classVec[l*classW +: classW], expCls);
			expSnan |= expCls[clsSnan];	// summary from the class bits
			expNan |= expCls[clsSnan] | expCls[clsQnan];
		end
		compareFlag("anySnan", anySnan, expSnan);
		compareFlag("anyNan", anyNan, expNan);
	endtask

	task automatic checkOutputs();
		for (int v = 0; v < 2 * numVecs; v++) begin
			waitOutValid(v);
			checkVector(v);
			@(negedge clk);	// step past this pulse
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		wordIn = '0;
		wordValid = 1'b0;
		lcgState = 32'h8399;
		$readmemh("tb/fpClassVec_stimulus.hex", stimMem);
		// the file's expected codes must agree with the ieee rules
		for (int w = 0; w < numWords; w++)
			compareClass($sformatf("stimulus class %0d", w), stimMem[w][fpWid +: classW],
				refClass(stimMem[w][fpWid-1:0]));

		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		// no input, so no output
		repeat (10) begin
			@(negedge clk);
			compareFlag("outValid", outValid, 1'b0);
		end

		fork
			driveWords();
			checkOutputs();
		join

		// no stray pulse after the last vector
		repeat (8) begin
			@(negedge clk);
			compareFlag("outValid", outValid, 1'b0);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* fpClassVec.f */
design/fpClassPkg.sv
design/fpLaneLoader.sv
design/fpDecompReg.sv
design/fpClassMerge.sv
design/fpClassVec.sv
tb/fpClassVec_sva.sv
tb/fpClassVecTb.sv

/* Makefile */
# Verilator build and run for the vector fp classifier

VERILATOR ?= verilator
TOP       := fpClassVecTb
FILELIST  := fpClassVec.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/fpClassVec_stimulus.hex */
// columns: ccc_wwwwwwww, one binary32 word per line, four lines per vector
// ccc is the expected 10-bit one-hot class code, wwwwwwww the word itself
// zeros and subnormals
010_00000000
008_80000000
020_00000001
004_807fffff
// normals
040_3f800000
002_bf800000
040_00800000
002_ff7fffff
// infinities mixed with the largest normal and a subnormal
080_7f800000
001_ff800000
040_7f7fffff
004_80400000
// quiet and signalling nans of both signs
200_7fc00000
100_7f800001
200_ffc00001
100_ffbfffff
// mixed, checks lane order
040_40490fdb
200_7fffffff
002_c2f60000
020_00400000
